/* verilog/armExecPkg.sv */
package armExecPkg;

    localparam int dataWidth = 32;  // Operand and result width

    // ARM data-processing opcode field, bits 24 to 21
    typedef enum logic [3:0] {
        opAnd = 4'd0,
        opEor = 4'd1,
        opSub = 4'd2,
        opRsb = 4'd3,
        opAdd = 4'd4,
        opAdc = 4'd5,
        opSbc = 4'd6,
        opRsc = 4'd7,
        opTst = 4'd8,
        opTeq = 4'd9,
        opCmp = 4'd10,
        opCmn = 4'd11,
        opOrr = 4'd12,
        opMov = 4'd13,
        opBic = 4'd14,
        opMvn = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        aluAnd   = 3'd0,  // Bitwise and
        aluXor   = 3'd1,  // Bitwise exclusive or
        aluSum   = 3'd2,  // Adder path
        aluOr    = 3'd3,  // Bitwise or
        aluPassB = 3'd4   // Single input move
    } aluOp_t;

    typedef struct packed {
        opcode_t                opcode;
        logic                   setFlags;   // S bit
        logic                   immediate;  // Operand B from imm8
        logic [3:0]             rotate;     // Rotate right by twice this
        logic [7:0]             imm8;
        logic [3:0]             rd;
        logic [dataWidth-1:0]   opA;
        logic [dataWidth-1:0]   opB;        // Register operand B
    } instrPacket_t;

    typedef struct packed {
        opcode_t                opcode;
        logic                   setFlags;
        logic [3:0]             rd;
        logic [dataWidth-1:0]   opA;
        logic [dataWidth-1:0]   opB;        // Already resolved
    } execPacket_t;

    typedef struct packed {
        aluOp_t aluOp;
        logic   invertB;        // Complement second operand
        logic   reverseInputs;  // Swap A and B
        logic   carryIn;
    } aluCtrl_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic writeNz;  // Update N and Z
        logic writeCv;  // Update C and V
        logic noWrite;  // Destination untouched
    } flagWrite_t;

    typedef struct packed {
        logic [3:0]             rd;
        logic [dataWidth-1:0]   data;
        logic                   regWrite;
    } resultPacket_t;

endpackage

/* verilog/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder (
    input  armExecPkg::opcode_t     opcode,
    input  logic                    setFlags,
    input  logic                    carryFlag,  // Current C for ADC style ops
    output armExecPkg::aluCtrl_t    ctrl,
    output armExecPkg::flagWrite_t  flagWrite
);

    logic isArith;    // Opcode uses the adder
    logic isCompare;  // TST TEQ CMP CMN

    always_comb begin
        ctrl.aluOp         = armExecPkg::aluSum;  // Adder unless told otherwise
        ctrl.invertB       = 1'b0;
        ctrl.reverseInputs = 1'b0;
        ctrl.carryIn       = 1'b0;
        isArith            = 1'b0;
        isCompare          = 1'b0;
        case (opcode)
            armExecPkg::opAnd: ctrl.aluOp = armExecPkg::aluAnd;
            armExecPkg::opEor: ctrl.aluOp = armExecPkg::aluXor;
            armExecPkg::opSub: begin
                ctrl.invertB = 1'b1;  // A + ~B + 1
                ctrl.carryIn = 1'b1;
                isArith      = 1'b1;
            end
            armExecPkg::opRsb: begin
                ctrl.invertB       = 1'b1;
                ctrl.reverseInputs = 1'b1;  // B - A
                ctrl.carryIn       = 1'b1;
                isArith            = 1'b1;
            end
            armExecPkg::opAdd: isArith = 1'b1;
            armExecPkg::opAdc: begin
                ctrl.carryIn = carryFlag;
                isArith      = 1'b1;
            end
            armExecPkg::opSbc: begin
                ctrl.invertB = 1'b1;
                ctrl.carryIn = carryFlag;  // Borrow is not C
                isArith      = 1'b1;
            end
            armExecPkg::opRsc: begin
                ctrl.invertB       = 1'b1;
                ctrl.reverseInputs = 1'b1;
                ctrl.carryIn       = carryFlag;
                isArith            = 1'b1;
            end
            armExecPkg::opTst: begin
                ctrl.aluOp = armExecPkg::aluAnd;  // AND without write
                isCompare  = 1'b1;
            end
            armExecPkg::opTeq: begin
                ctrl.aluOp = armExecPkg::aluXor;
                isCompare  = 1'b1;
            end
            armExecPkg::opCmp: begin
                ctrl.invertB = 1'b1;  // SUB without write
                ctrl.carryIn = 1'b1;
                isArith      = 1'b1;
                isCompare    = 1'b1;
            end
            armExecPkg::opCmn: begin
                isArith   = 1'b1;  // ADD without write
                isCompare = 1'b1;
            end
            armExecPkg::opOrr: ctrl.aluOp = armExecPkg::aluOr;
            armExecPkg::opMov: ctrl.aluOp = armExecPkg::aluPassB;
            armExecPkg::opBic: begin
                ctrl.aluOp   = armExecPkg::aluAnd;  // A & ~B
                ctrl.invertB = 1'b1;
            end
            armExecPkg::opMvn: begin
                ctrl.aluOp   = armExecPkg::aluPassB;  // ~B
                ctrl.invertB = 1'b1;
            end
            default: ctrl.aluOp = armExecPkg::aluSum;
        endcase

        // Compares set flags whatever the S bit says
        flagWrite.writeNz = setFlags | isCompare;
        flagWrite.writeCv = (setFlags | isCompare) & isArith;  // Logic ops keep C and V
        flagWrite.noWrite = isCompare;
    end

endmodule

/* verilog/dataAlu.sv */
`timescale 1ns/1ps

module dataAlu (
    input  logic [armExecPkg::dataWidth-1:0] a,
    input  logic [armExecPkg::dataWidth-1:0] b,
    input  armExecPkg::aluCtrl_t             ctrl,
    output logic [armExecPkg::dataWidth-1:0] y,
    output logic                             carryOut,
    output logic                             overflow
);

    logic [armExecPkg::dataWidth-1:0] aSel;  // After optional swap
    logic [armExecPkg::dataWidth-1:0] bSel;
    logic [armExecPkg::dataWidth-1:0] bOp;   // After optional invert
    logic [armExecPkg::dataWidth:0]   sum;   // Extra bit holds carry

    // Reverse subtract just swaps the inputs
    assign aSel = ctrl.reverseInputs ? b : a;
    assign bSel = ctrl.reverseInputs ? a : b;
    assign bOp  = ctrl.invertB ? ~bSel : bSel;

    assign sum = {1'b0, aSel} + {1'b0, bOp}
               + {{armExecPkg::dataWidth{1'b0}}, ctrl.carryIn};

    assign carryOut = sum[armExecPkg::dataWidth];  // Not borrow for subtracts

    // Same sign inputs and a sign flip in the sum
    assign overflow = (aSel[armExecPkg::dataWidth-1] == bOp[armExecPkg::dataWidth-1])
                    & (sum[armExecPkg::dataWidth-1] != aSel[armExecPkg::dataWidth-1]);

    always_comb begin
        case (ctrl.aluOp)
            armExecPkg::aluAnd:   y = aSel & bOp;  // AND TST BIC
            armExecPkg::aluXor:   y = aSel ^ bOp;  // EOR TEQ
            armExecPkg::aluSum:   y = sum[armExecPkg::dataWidth-1:0];
            armExecPkg::aluOr:    y = aSel | bOp;  // ORR
            armExecPkg::aluPassB: y = bOp;         // MOV MVN
            default:              y = sum[armExecPkg::dataWidth-1:0];
        endcase
    end

endmodule

/* verilog/flagRegister.sv */
`timescale 1ns/1ps

module flagRegister (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             update,     // Instruction in execute
    input  armExecPkg::flagWrite_t           flagWrite,
    input  logic [armExecPkg::dataWidth-1:0] result,
    input  logic                             carryOut,
    input  logic                             overflow,
    output armExecPkg::flags_t               flags
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
        end else if (update) begin
            if (flagWrite.writeNz) begin
                flags.n <= result[armExecPkg::dataWidth-1];  // Sign bit
                flags.z <= (result == '0);
            end
            if (flagWrite.writeCv) begin
                flags.c <= carryOut;
                flags.v <= overflow;
            end
        end
    end

    // Decoder never updates C and V alone
    cvImpliesNz: assert property (
        @(posedge clk) disable iff (!arstN)
        (update && flagWrite.writeCv) |-> flagWrite.writeNz
    ) else $error("flagRegister: writeCv without writeNz");

    // Flags stay known once out of reset
    flagsKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        !$isunknown(flags)
    ) else $error("flagRegister: unknown flags %h", flags);

endmodule

/* verilog/operandStage.sv */
`timescale 1ns/1ps

module operandStage (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     instrValid,  // One cycle strobe
    input  armExecPkg::instrPacket_t instr,
    output logic                     execValid,
    output armExecPkg::execPacket_t  exec
);

    logic [armExecPkg::dataWidth-1:0]   immWord;      // imm8 zero extended
    logic [2*armExecPkg::dataWidth-1:0] immPair;      // Doubled word for rotate
    logic [4:0]                         rotAmount;    // Twice the rotate field
    logic [armExecPkg::dataWidth-1:0]   opBResolved;

    assign immWord   = {{(armExecPkg::dataWidth-8){1'b0}}, instr.imm8};
    assign rotAmount = {instr.rotate, 1'b0};
    assign immPair   = {immWord, immWord} >> rotAmount;  // Low half is the rotate right

    assign opBResolved = instr.immediate ? immPair[armExecPkg::dataWidth-1:0] : instr.opB;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            execValid <= 1'b0;
        end else begin
            execValid <= instrValid;
        end
    end

    // Payload holds until the next strobe
    always_ff @(posedge clk) begin
        if (instrValid) begin
            exec.opcode   <= instr.opcode;
            exec.setFlags <= instr.setFlags;
            exec.rd       <= instr.rd;
            exec.opA      <= instr.opA;
            exec.opB      <= opBResolved;
        end
    end

    instrKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        instrValid |-> !$isunknown(instr)
    ) else $error("operandStage: unknown bits in instr %h", instr);

endmodule

/* verilog/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      execValid,
    input  armExecPkg::execPacket_t   exec,
    output logic                      resultValid,
    output armExecPkg::resultPacket_t result,
    output armExecPkg::flags_t        flags
);

    armExecPkg::aluCtrl_t             aluCtrl;
    armExecPkg::flagWrite_t           flagWrite;
    logic [armExecPkg::dataWidth-1:0] aluY;
    logic                             aluCarry;
    logic                             aluOverflow;

    aluDecoder aluDecoder_i (
        .opcode    (exec.opcode),
        .setFlags  (exec.setFlags),
        .carryFlag (flags.c),  // Written by the instruction just ahead
        .ctrl      (aluCtrl),
        .flagWrite (flagWrite)
    );

    dataAlu dataAlu_i (
        .a        (exec.opA),
        .b        (exec.opB),
        .ctrl     (aluCtrl),
        .y        (aluY),
        .carryOut (aluCarry),
        .overflow (aluOverflow)
    );

    // Flags move on the same edge as the result register
    flagRegister flagRegister_i (
        .clk       (clk),
        .arstN     (arstN),
        .update    (execValid),
        .flagWrite (flagWrite),
        .result    (aluY),
        .carryOut  (aluCarry),
        .overflow  (aluOverflow),
        .flags     (flags)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= execValid;
        end
    end

    always_ff @(posedge clk) begin
        if (execValid) begin
            result.rd       <= exec.rd;
            result.data     <= aluY;
            result.regWrite <= !flagWrite.noWrite;  // Compares leave rd alone
        end
    end

endmodule

/* verilog/execUnit.sv */
`timescale 1ns/1ps

module execUnit (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      instrValid,
    input  armExecPkg::instrPacket_t  instr,
    output logic                      resultValid,
    output armExecPkg::resultPacket_t result,
    output armExecPkg::flags_t        flags
);

    logic                    execValid;  // Stage one to stage two strobe
    armExecPkg::execPacket_t exec;       // Operand B already resolved

    operandStage operandStage_i (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .execValid  (execValid),
        .exec       (exec)
    );

    executeStage executeStage_i (
        .clk         (clk),
        .arstN       (arstN),
        .execValid   (execValid),
        .exec        (exec),
        .resultValid (resultValid),
        .result      (result),
        .flags       (flags)
    );

endmodule

/* tests/execUnitTb.sv */
`timescale 1ns/1ps

module execUnitTb;

    localparam int randomCount   = 1000;
    localparam int directedMax   = 200;  // Upper bound on directed instructions
    localparam int timeoutCycles = (randomCount + directedMax) * 2 + 50;  // At most one gap each

    typedef struct packed {
        armExecPkg::resultPacket_t res;
        armExecPkg::flags_t        flg;
    } expect_t;

    logic                      clk;
    logic                      arstN;
    logic                      instrValid;
    armExecPkg::instrPacket_t  instr;
    logic                      resultValid;
    armExecPkg::resultPacket_t result;
    armExecPkg::flags_t        flags;

    armExecPkg::instrPacket_t  instrQ[$];  // Oldest in flight first
    int                        issueQ[$];  // Drive cycle of each entry
    armExecPkg::flags_t        modelFlags;
    armExecPkg::instrPacket_t  popped;
    int                        poppedIssue;
    expect_t                   expected;
    int                        cycleCount;
    logic [31:0]               lfsrState;

    logic [31:0] edgeVals [4] = '{32'h0, 32'hffffffff, 32'h7fffffff, 32'h80000000};

    execUnit execUnit_i (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .resultValid (resultValid),
        .result      (result),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial cycleCount = 0;
    always @(posedge clk) cycleCount <= cycleCount + 1;

    task automatic stopOnError;
        $display("Done: errors found");
        $fatal(1, "stopping at first error");
    endtask

    // Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i]      = lfsrState[0];
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        end
        return r;
    endfunction

    // ARM data-processing semantics where C means no borrow
    function automatic expect_t refExecute(input armExecPkg::instrPacket_t p,
                                           input armExecPkg::flags_t f);
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] y;
        logic [32:0] wide;
        logic [5:0]  amt;
        logic        c;
        logic        v;
        logic        arith;
        logic        cmp;
        a     = p.opA;
        amt   = {1'b0, p.rotate, 1'b0};
        b     = p.immediate ? (({24'b0, p.imm8} >> amt) | ({24'b0, p.imm8} << (6'd32 - amt)))
                            : p.opB;
        c     = f.c;
        v     = f.v;
        arith = 1'b1;
        cmp   = (p.opcode inside {armExecPkg::opTst, armExecPkg::opTeq,
                                  armExecPkg::opCmp, armExecPkg::opCmn});
        case (p.opcode)
            armExecPkg::opAnd, armExecPkg::opTst: begin
                y = a & b;
                arith = 1'b0;
            end
            armExecPkg::opEor, armExecPkg::opTeq: begin
                y = a ^ b;
                arith = 1'b0;
            end
            armExecPkg::opSub, armExecPkg::opCmp: begin
                y = a - b;
                c = (a >= b);
                v = (a[31] != b[31]) && (y[31] != a[31]);
            end
            armExecPkg::opRsb: begin
                y = b - a;
                c = (b >= a);
                v = (a[31] != b[31]) && (y[31] != b[31]);
            end
            armExecPkg::opAdd, armExecPkg::opCmn, armExecPkg::opAdc: begin
                wide = {1'b0, a} + {1'b0, b}
                     + {32'b0, (p.opcode == armExecPkg::opAdc) ? f.c : 1'b0};
                y = wide[31:0];
                c = wide[32];
                v = (a[31] == b[31]) && (y[31] != a[31]);
            end
            armExecPkg::opSbc: begin
                y = a - b - {31'b0, ~f.c};  // Borrow is not C
                c = ({1'b0, a} >= ({1'b0, b} + {32'b0, ~f.c}));
                v = (a[31] != b[31]) && (y[31] != a[31]);
            end
            armExecPkg::opRsc: begin
                y = b - a - {31'b0, ~f.c};
                c = ({1'b0, b} >= ({1'b0, a} + {32'b0, ~f.c}));
                v = (a[31] != b[31]) && (y[31] != b[31]);
            end
            armExecPkg::opOrr: begin
                y = a | b;
                arith = 1'b0;
            end
            armExecPkg::opMov: begin
                y = b;
                arith = 1'b0;
            end
            armExecPkg::opBic: begin
                y = a & ~b;
                arith = 1'b0;
            end
            default: begin
                y = ~b;  // MVN
                arith = 1'b0;
            end
        endcase
        e.res.rd       = p.rd;
        e.res.data     = y;
        e.res.regWrite = !cmp;
        e.flg          = f;
        if (p.setFlags || cmp) begin
            e.flg.n = y[31];
            e.flg.z = (y == 32'h0);
            if (arith) begin
                e.flg.c = c;
                e.flg.v = v;
            end
        end
        return e;
    endfunction

    function automatic armExecPkg::instrPacket_t makeInstr(input armExecPkg::opcode_t op,
                                                           input logic s,
                                                           input logic [31:0] a,
                                                           input logic [31:0] b);
        armExecPkg::instrPacket_t p;
        p          = '0;
        p.opcode   = op;
        p.setFlags = s;
        p.rd       = op;  // Opcode doubles as rd to vary it
        p.opA      = a;
        p.opB      = b;
        return p;
    endfunction

    function automatic armExecPkg::instrPacket_t randomInstr();
        armExecPkg::instrPacket_t p;
        logic [31:0] t;
        t          = randomBits(4);
        p.opcode   = armExecPkg::opcode_t'(t[3:0]);
        t          = randomBits(1);
        p.setFlags = t[0];
        t          = randomBits(1);
        p.immediate = t[0];
        t          = randomBits(4);
        p.rotate   = t[3:0];
        t          = randomBits(8);
        p.imm8     = t[7:0];
        t          = randomBits(4);
        p.rd       = t[3:0];
        p.opA      = randomBits(32);
        p.opB      = randomBits(32);
        return p;
    endfunction

    task automatic issueInstr(input armExecPkg::instrPacket_t p);
        @(negedge clk);
        instrValid = 1'b1;
        instr      = p;
        instrQ.push_back(p);
        issueQ.push_back(cycleCount);  // Sampled at the next rising edge
    endtask

    task automatic idleCycle;
        @(negedge clk);
        instrValid = 1'b0;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arstN) begin
            if (resultValid) begin
                assert (instrQ.size() != 0) else begin
                    $display("resultValid went high with no instruction in flight");
                    stopOnError();
                end
                popped      = instrQ.pop_front();
                poppedIssue = issueQ.pop_front();
                expected    = refExecute(popped, modelFlags);
                modelFlags  = expected.flg;
                assert (cycleCount == poppedIssue + 2) else begin
                    $display("Result strobe came %0d edges after issue instead of 2",
                             cycleCount - poppedIssue);
                    stopOnError();
                end
                assert (result.rd == expected.res.rd) else begin
                    $display("ERR result.rd got %h expected %h", result.rd, expected.res.rd);
                    stopOnError();
                end
                assert (result.data == expected.res.data) else begin
                    $display("ERR result.data got %h expected %h",
                             result.data, expected.res.data);
                    stopOnError();
                end
                assert (result.regWrite == expected.res.regWrite) else begin
                    $display("ERR result.regWrite got %h expected %h",
                             result.regWrite, expected.res.regWrite);
                    stopOnError();
                end
            end
            // Flags only move with a result strobe
            assert (flags == modelFlags) else begin
                $display("ERR flags got %h expected %h", flags, modelFlags);
                stopOnError();
            end
        end
    end

    initial begin
        wait (cycleCount >= timeoutCycles);
        $display("Timeout after %0d cycles with results still missing", timeoutCycles);
        stopOnError();
    end

    initial begin
        logic [31:0] gap;
        lfsrState  = 32'h5bbc;
        modelFlags = '0;
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        repeat (3) idleCycle();  // Idle outputs after reset

        // ADDS first sets C and V for the logic ops
        issueInstr(makeInstr(armExecPkg::opAdd, 1'b1, 32'h80000000, 32'h80000000));
        foreach (edgeVals[i]) begin
            for (int s = 0; s < 2; s++) begin
                issueInstr(makeInstr(armExecPkg::opAnd, s[0], edgeVals[i], 32'h8000ff00));
                issueInstr(makeInstr(armExecPkg::opEor, s[0], edgeVals[i], 32'h7fffffff));
                issueInstr(makeInstr(armExecPkg::opOrr, s[0], edgeVals[i], 32'h0));
                issueInstr(makeInstr(armExecPkg::opBic, s[0], edgeVals[i], 32'hffff0000));
                issueInstr(makeInstr(armExecPkg::opMov, s[0], 32'h0, edgeVals[i]));
                issueInstr(makeInstr(armExecPkg::opMvn, s[0], 32'h0, edgeVals[i]));
            end
        end
        idleCycle();

        // Arithmetic on edge operands
        foreach (edgeVals[i]) begin
            foreach (edgeVals[j]) begin
                issueInstr(makeInstr(armExecPkg::opAdd, 1'b1, edgeVals[i], edgeVals[j]));
                issueInstr(makeInstr(armExecPkg::opSub, 1'b1, edgeVals[i], edgeVals[j]));
                issueInstr(makeInstr(armExecPkg::opRsb, 1'b1, edgeVals[i], edgeVals[j]));
            end
        end
        idleCycle();

        // Carry chains where each op reads the C just written
        foreach (edgeVals[i]) begin
            issueInstr(makeInstr(armExecPkg::opAdc, 1'b1, edgeVals[i], 32'hffffffff));
            issueInstr(makeInstr(armExecPkg::opSbc, 1'b1, edgeVals[i], 32'h1));
            issueInstr(makeInstr(armExecPkg::opRsc, 1'b1, 32'h1, edgeVals[i]));
            issueInstr(makeInstr(armExecPkg::opAdc, 1'b1, 32'h0, 32'h0));
        end
        idleCycle();

        // Compares with S low still set flags
        foreach (edgeVals[i]) begin
            issueInstr(makeInstr(armExecPkg::opTst, 1'b0, edgeVals[i], 32'h80000001));
            issueInstr(makeInstr(armExecPkg::opTeq, 1'b0, edgeVals[i], 32'hffffffff));
            issueInstr(makeInstr(armExecPkg::opCmp, 1'b0, edgeVals[i], 32'h7fffffff));
            issueInstr(makeInstr(armExecPkg::opCmn, 1'b0, edgeVals[i], 32'h80000000));
        end
        idleCycle();

        for (int k = 0; k < randomCount; k++) begin
            issueInstr(randomInstr());
            gap = randomBits(2);
            if (gap[1:0] == 2'b11) begin
                idleCycle();  // Gap in about a quarter of slots
            end
        end
        idleCycle();

        while (instrQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

/* armExec.f */
verilog/armExecPkg.sv
verilog/aluDecoder.sv
verilog/dataAlu.sv
verilog/flagRegister.sv
verilog/operandStage.sv
verilog/executeStage.sv
verilog/execUnit.sv
tests/execUnitTb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module execUnitTb -Mdir obj_dir -f armExec.f

run: compile
	-./obj_dir/VexecUnitTb > sim.log 2>&1
	cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
